//--- afu_route_pkg.sv
// ---------------------------------------------------------------------
// AFU routing package
// Widths, function port indices and the PF/VF routing lookup shared
// by the request pipeline and the FLR router
// ---------------------------------------------------------------------
package afu_route_pkg;

   // ------------------------------------------------------------------
   // Field widths
   // ------------------------------------------------------------------
   localparam int NUM_PORTS = 3;

   typedef logic [2:0]           pf_num_t;
   typedef logic [3:0]           vf_num_t;
   typedef logic [31:0]          payload_t;
   typedef logic [1:0]           port_id_t;
   // One request/ack bit per function port
   typedef logic [NUM_PORTS-1:0] port_vec_t;

   // ------------------------------------------------------------------
   // Routing table constants
   // ------------------------------------------------------------------
   // Management function, PF0 with no VF
   localparam port_id_t MGMT_PID  = 2'd0;
   // Port gasket group, PF0 VF0 up to PG_NUM_VF-1
   localparam port_id_t PG_PID    = 2'd1;
   // Static region catches everything else
   localparam port_id_t SR_PID    = 2'd2;
   localparam vf_num_t  PG_NUM_VF = 4'd3;

   // FLR sequencing states
   typedef enum logic [1:0] {
      IDLE,
      PORT_REQ,
      PORT_REL,
      HOST_ACK
   } flr_state_t;

   // Map a PF/VF to its function port
   // Rules are checked in order, first match wins
   function automatic port_id_t route_port(
      input pf_num_t pf,
      input vf_num_t vf,
      input logic    vf_active
   );
      port_id_t port;
      if ((pf == '0) && !vf_active) begin
         port = MGMT_PID;
      end else if ((pf == '0) && (vf < PG_NUM_VF)) begin
         port = PG_PID;
      end else begin
         // Default route
         port = SR_PID;
      end
      return port;
   endfunction

endpackage

//--- host_rx_stage.sv
// ---------------------------------------------------------------------
// Host receive stage
// Takes host requests over four-phase req/ack, holds one item and
// offers it to the routing stage with valid/ready
// ---------------------------------------------------------------------
`timescale 1ns/1ns

module host_rx_stage (
   input  logic                    clk_div2,
   input  logic                    i_rst_n,
   // Host request, four-phase
   input  logic                    i_req,
   input  afu_route_pkg::pf_num_t  i_req_pf,
   input  afu_route_pkg::vf_num_t  i_req_vf,
   input  logic                    i_req_vf_active,
   input  afu_route_pkg::payload_t i_req_data,
   output logic                    o_req_ack,
   // Downstream item
   output logic                    o_rx_valid,
   input  logic                    i_rx_ready,
   output afu_route_pkg::pf_num_t  o_rx_pf,
   output afu_route_pkg::vf_num_t  o_rx_vf,
   output logic                    o_rx_vf_active,
   output afu_route_pkg::payload_t o_rx_data
);

   logic full;
   logic take;

   // New request phase starts when req is high and the previous ack
   // has already been withdrawn
   // Only taken while the holding register is free
   assign take = i_req && !o_req_ack && !full;

   // Control state
   always_ff @(posedge clk_div2 or negedge i_rst_n) begin
      if (!i_rst_n) begin
         full      <= 1'b0;
         o_req_ack <= 1'b0;
      end else begin
         if (take) begin
            full      <= 1'b1;
            o_req_ack <= 1'b1;
         end else begin
            // Item leaves on a valid/ready beat
            if (full && i_rx_ready) begin
               full <= 1'b0;
            end
            // Return to zero once host drops req
            if (o_req_ack && !i_req) begin
               o_req_ack <= 1'b0;
            end
         end
      end
   end

   // Payload capture, fields are stable while req is high
   always_ff @(posedge clk_div2) begin
      if (take) begin
         o_rx_pf        <= i_req_pf;
         o_rx_vf        <= i_req_vf;
         o_rx_vf_active <= i_req_vf_active;
         o_rx_data      <= i_req_data;
      end
   end

   assign o_rx_valid = full;

endmodule

//--- pfvf_route_stage.sv
// ---------------------------------------------------------------------
// PF/VF routing stage
// Looks up the destination function port of each accepted item and
// holds it with its port ID for the output stage
// ---------------------------------------------------------------------
`timescale 1ns/1ns

module pfvf_route_stage (
   input  logic                    clk_div2,
   input  logic                    i_rst_n,
   // From host receive stage
   input  logic                    i_rx_valid,
   output logic                    o_rx_ready,
   input  afu_route_pkg::pf_num_t  i_rx_pf,
   input  afu_route_pkg::vf_num_t  i_rx_vf,
   input  logic                    i_rx_vf_active,
   input  afu_route_pkg::payload_t i_rx_data,
   // To port output stage
   output logic                    o_rt_valid,
   input  logic                    i_rt_ready,
   output afu_route_pkg::port_id_t o_rt_port,
   output afu_route_pkg::pf_num_t  o_rt_pf,
   output afu_route_pkg::vf_num_t  o_rt_vf,
   output logic                    o_rt_vf_active,
   output afu_route_pkg::payload_t o_rt_data
);

   logic full;
   logic accept;

   // Ready when empty, or when the held item moves on this edge
   assign o_rx_ready = !full || i_rt_ready;
   assign accept     = i_rx_valid && o_rx_ready;

   always_ff @(posedge clk_div2 or negedge i_rst_n) begin
      if (!i_rst_n) begin
         full <= 1'b0;
      end else if (accept) begin
         full <= 1'b1;
      end else if (i_rt_ready) begin
         full <= 1'b0;
      end
   end

   // Route lookup happens on the way in so the port ID is ready
   // together with rt_valid one cycle later
   always_ff @(posedge clk_div2) begin
      if (accept) begin
         o_rt_port      <= afu_route_pkg::route_port(i_rx_pf, i_rx_vf,
                                                     i_rx_vf_active);
         o_rt_pf        <= i_rx_pf;
         o_rt_vf        <= i_rx_vf;
         o_rt_vf_active <= i_rx_vf_active;
         o_rt_data      <= i_rx_data;
      end
   end

   assign o_rt_valid = full;

endmodule

//--- port_out_stage.sv
// ---------------------------------------------------------------------
// Port output stage
// Presents one routed item on its function port and runs the request
// side of the four-phase cycle against that port's ack
// ---------------------------------------------------------------------
`timescale 1ns/1ns

module port_out_stage (
   input  logic                     clk_div2,
   input  logic                     i_rst_n,
   // From routing stage
   input  logic                     i_rt_valid,
   output logic                     o_rt_ready,
   input  afu_route_pkg::port_id_t  i_rt_port,
   input  afu_route_pkg::pf_num_t   i_rt_pf,
   input  afu_route_pkg::vf_num_t   i_rt_vf,
   input  logic                     i_rt_vf_active,
   input  afu_route_pkg::payload_t  i_rt_data,
   // Function ports, four-phase
   output afu_route_pkg::port_vec_t o_port_req,
   input  afu_route_pkg::port_vec_t i_port_ack,
   output afu_route_pkg::pf_num_t   o_port_pf,
   output afu_route_pkg::vf_num_t   o_port_vf,
   output logic                     o_port_vf_active,
   output afu_route_pkg::payload_t  o_port_data
);

   // Item held from accept until its ack has gone back low
   logic                    busy;
   afu_route_pkg::port_id_t sel_port;
   logic                    sel_ack;
   logic                    accept;
   logic                    req_on;

   assign o_rt_ready = !busy;
   assign accept     = i_rt_valid && o_rt_ready;
   assign req_on     = |o_port_req;

   // Only the ack of the port we drive counts
   assign sel_ack = i_port_ack[sel_port];

   // ------------------------------------------------------------------
   // Four-phase request sequencing
   // ------------------------------------------------------------------
   always_ff @(posedge clk_div2 or negedge i_rst_n) begin
      if (!i_rst_n) begin
         busy       <= 1'b0;
         o_port_req <= '0;
         sel_port   <= afu_route_pkg::MGMT_PID;
      end else begin
         if (accept) begin
            busy       <= 1'b1;
            sel_port   <= i_rt_port;
            // One-hot request bit for the routed port
            o_port_req <= afu_route_pkg::port_vec_t'(1) << i_rt_port;
         end else if (busy && req_on && sel_ack) begin
            // Port took the item, withdraw request
            o_port_req <= '0;
         end else if (busy && !req_on && !sel_ack) begin
            // Ack back to zero, cycle done
            busy <= 1'b0;
         end
      end
   end

   // ------------------------------------------------------------------
   // Payload hold
   // ------------------------------------------------------------------
   // Fields stay stable for the whole cycle on the port
   always_ff @(posedge clk_div2) begin
      if (accept) begin
         o_port_pf        <= i_rt_pf;
         o_port_vf        <= i_rt_vf;
         o_port_vf_active <= i_rt_vf_active;
         o_port_data      <= i_rt_data;
      end
   end

endmodule

//--- flr_router.sv
// ---------------------------------------------------------------------
// FLR router
// Sends one host function-level reset to the port that owns the
// PF/VF and answers the host once that port has acknowledged
// ---------------------------------------------------------------------
`timescale 1ns/1ns

module flr_router (
   input  logic                     clk_div2,
   input  logic                     i_rst_n,
   // Host FLR, four-phase
   input  logic                     i_flr_req,
   input  afu_route_pkg::pf_num_t   i_flr_pf,
   input  afu_route_pkg::vf_num_t   i_flr_vf,
   input  logic                     i_flr_vf_active,
   output logic                     o_flr_ack,
   // Port side FLR, four-phase
   output afu_route_pkg::port_vec_t o_flr_port_req,
   input  afu_route_pkg::port_vec_t i_flr_port_ack,
   output afu_route_pkg::pf_num_t   o_flr_port_pf,
   output afu_route_pkg::vf_num_t   o_flr_port_vf
);

   afu_route_pkg::flr_state_t state;
   afu_route_pkg::flr_state_t state_nxt;
   afu_route_pkg::port_id_t   flr_port;
   logic                      port_ack;
   logic                      start;

   assign port_ack = i_flr_port_ack[flr_port];
   assign start    = (state == afu_route_pkg::IDLE) && i_flr_req;

   // ------------------------------------------------------------------
   // Next state
   // ------------------------------------------------------------------
   always_comb begin
      state_nxt = state;
      case (state)
         afu_route_pkg::IDLE: begin
            if (i_flr_req) begin
               state_nxt = afu_route_pkg::PORT_REQ;
            end
         end
         // Hold port request until the owner acks
         afu_route_pkg::PORT_REQ: begin
            if (port_ack) begin
               state_nxt = afu_route_pkg::PORT_REL;
            end
         end
         // Request dropped, wait for port ack to return low
         afu_route_pkg::PORT_REL: begin
            if (!port_ack) begin
               state_nxt = afu_route_pkg::HOST_ACK;
            end
         end
         // Host sees ack until it drops its request
         afu_route_pkg::HOST_ACK: begin
            if (!i_flr_req) begin
               state_nxt = afu_route_pkg::IDLE;
            end
         end
         default: begin
            state_nxt = afu_route_pkg::IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_div2 or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state    <= afu_route_pkg::IDLE;
         flr_port <= afu_route_pkg::MGMT_PID;
      end else begin
         state <= state_nxt;
         if (start) begin
            flr_port <= afu_route_pkg::route_port(i_flr_pf, i_flr_vf,
                                                  i_flr_vf_active);
         end
      end
   end

   // Target function, held for the whole port cycle
   always_ff @(posedge clk_div2) begin
      if (start) begin
         o_flr_port_pf <= i_flr_pf;
         o_flr_port_vf <= i_flr_vf;
      end
   end

   // ------------------------------------------------------------------
   // Outputs decoded from state
   // ------------------------------------------------------------------
   assign o_flr_port_req = (state == afu_route_pkg::PORT_REQ) ?
                           (afu_route_pkg::port_vec_t'(1) << flr_port) : '0;
   assign o_flr_ack      = (state == afu_route_pkg::HOST_ACK);

endmodule

//--- afu_route_top.sv
// ---------------------------------------------------------------------
// AFU routing top level
// Three-stage PF/VF request pipeline from host to function ports,
// alongside the FLR router
// ---------------------------------------------------------------------
`timescale 1ns/1ns

module afu_route_top (
   input  logic                     clk_div2,
   input  logic                     i_rst_n,
   // Host request
   input  logic                     i_req,
   input  afu_route_pkg::pf_num_t   i_req_pf,
   input  afu_route_pkg::vf_num_t   i_req_vf,
   input  logic                     i_req_vf_active,
   input  afu_route_pkg::payload_t  i_req_data,
   output logic                     o_req_ack,
   // Function ports
   output afu_route_pkg::port_vec_t o_port_req,
   input  afu_route_pkg::port_vec_t i_port_ack,
   output afu_route_pkg::pf_num_t   o_port_pf,
   output afu_route_pkg::vf_num_t   o_port_vf,
   output logic                     o_port_vf_active,
   output afu_route_pkg::payload_t  o_port_data,
   // Host FLR
   input  logic                     i_flr_req,
   input  afu_route_pkg::pf_num_t   i_flr_pf,
   input  afu_route_pkg::vf_num_t   i_flr_vf,
   input  logic                     i_flr_vf_active,
   output logic                     o_flr_ack,
   // Port FLR
   output afu_route_pkg::port_vec_t o_flr_port_req,
   input  afu_route_pkg::port_vec_t i_flr_port_ack,
   output afu_route_pkg::pf_num_t   o_flr_port_pf,
   output afu_route_pkg::vf_num_t   o_flr_port_vf
);

   // ------------------------------------------------------------------
   // Stage links
   // ------------------------------------------------------------------
   // Receive to routing
   logic                    rx_valid;
   logic                    rx_ready;
   afu_route_pkg::pf_num_t  rx_pf;
   afu_route_pkg::vf_num_t  rx_vf;
   logic                    rx_vf_active;
   afu_route_pkg::payload_t rx_data;
   // Routing to output
   logic                    rt_valid;
   logic                    rt_ready;
   afu_route_pkg::port_id_t rt_port;
   afu_route_pkg::pf_num_t  rt_pf;
   afu_route_pkg::vf_num_t  rt_vf;
   logic                    rt_vf_active;
   afu_route_pkg::payload_t rt_data;

   host_rx_stage u_host_rx (
      .clk_div2        (clk_div2),
      .i_rst_n         (i_rst_n),
      .i_req           (i_req),
      .i_req_pf        (i_req_pf),
      .i_req_vf        (i_req_vf),
      .i_req_vf_active (i_req_vf_active),
      .i_req_data      (i_req_data),
      .o_req_ack       (o_req_ack),
      .o_rx_valid      (rx_valid),
      .i_rx_ready      (rx_ready),
      .o_rx_pf         (rx_pf),
      .o_rx_vf         (rx_vf),
      .o_rx_vf_active  (rx_vf_active),
      .o_rx_data       (rx_data)
   );

   pfvf_route_stage u_route (
      .clk_div2       (clk_div2),
      .i_rst_n        (i_rst_n),
      .i_rx_valid     (rx_valid),
      .o_rx_ready     (rx_ready),
      .i_rx_pf        (rx_pf),
      .i_rx_vf        (rx_vf),
      .i_rx_vf_active (rx_vf_active),
      .i_rx_data      (rx_data),
      .o_rt_valid     (rt_valid),
      .i_rt_ready     (rt_ready),
      .o_rt_port      (rt_port),
      .o_rt_pf        (rt_pf),
      .o_rt_vf        (rt_vf),
      .o_rt_vf_active (rt_vf_active),
      .o_rt_data      (rt_data)
   );

   port_out_stage u_port_out (
      .clk_div2         (clk_div2),
      .i_rst_n          (i_rst_n),
      .i_rt_valid       (rt_valid),
      .o_rt_ready       (rt_ready),
      .i_rt_port        (rt_port),
      .i_rt_pf          (rt_pf),
      .i_rt_vf          (rt_vf),
      .i_rt_vf_active   (rt_vf_active),
      .i_rt_data        (rt_data),
      .o_port_req       (o_port_req),
      .i_port_ack       (i_port_ack),
      .o_port_pf        (o_port_pf),
      .o_port_vf        (o_port_vf),
      .o_port_vf_active (o_port_vf_active),
      .o_port_data      (o_port_data)
   );

   // ------------------------------------------------------------------
   // FLR path, independent of the request pipeline
   // ------------------------------------------------------------------
   flr_router u_flr (
      .clk_div2        (clk_div2),
      .i_rst_n         (i_rst_n),
      .i_flr_req       (i_flr_req),
      .i_flr_pf        (i_flr_pf),
      .i_flr_vf        (i_flr_vf),
      .i_flr_vf_active (i_flr_vf_active),
      .o_flr_ack       (o_flr_ack),
      .o_flr_port_req  (o_flr_port_req),
      .i_flr_port_ack  (i_flr_port_ack),
      .o_flr_port_pf   (o_flr_port_pf),
      .o_flr_port_vf   (o_flr_port_vf)
   );

endmodule

//--- tb_afu_route.sv
// ---------------------------------------------------------------------
// AFU routing testbench
// Drives host requests and FLRs from a table through the DUT and
// checks port selection, fields, ordering and back-pressure
// ---------------------------------------------------------------------
`timescale 1ns/1ns

module tb_afu_route;

   localparam int NUM_ENT = 12;
   localparam int TMO     = 200;
   localparam int IDLE_TMO = 20000;

   // Table entry with the request fields and the port the routing rules give
   typedef struct packed {
      afu_route_pkg::pf_num_t  pf;
      afu_route_pkg::vf_num_t  vf;
      logic                    vf_active;
      afu_route_pkg::payload_t data;
      afu_route_pkg::port_id_t port;
   } entry_t;

   logic                     clk_div2;
   logic                     i_rst_n;
   logic                     i_req;
   afu_route_pkg::pf_num_t   i_req_pf;
   afu_route_pkg::vf_num_t   i_req_vf;
   logic                     i_req_vf_active;
   afu_route_pkg::payload_t  i_req_data;
   logic                     o_req_ack;
   afu_route_pkg::port_vec_t o_port_req;
   afu_route_pkg::port_vec_t i_port_ack;
   afu_route_pkg::pf_num_t   o_port_pf;
   afu_route_pkg::vf_num_t   o_port_vf;
   logic                     o_port_vf_active;
   afu_route_pkg::payload_t  o_port_data;
   logic                     i_flr_req;
   afu_route_pkg::pf_num_t   i_flr_pf;
   afu_route_pkg::vf_num_t   i_flr_vf;
   logic                     i_flr_vf_active;
   logic                     o_flr_ack;
   afu_route_pkg::port_vec_t o_flr_port_req;
   afu_route_pkg::port_vec_t i_flr_port_ack;
   afu_route_pkg::pf_num_t   o_flr_port_pf;
   afu_route_pkg::vf_num_t   o_flr_port_vf;

   entry_t     tbl [NUM_ENT];
   int         err_val   = 0;
   int         err_other = 0;
   int         deliv_cnt = 0;
   // Port responder stalls while set
   logic       hold      = 1'b0;
   logic [7:0] lfsr      = 8'd28;

   afu_route_top uut (.*);

   initial begin
      clk_div2 = 1'b0;
      forever #2 clk_div2 = ~clk_div2;
   end

   // ------------------------------------------------------------------
   // Reporting
   // ------------------------------------------------------------------
   task automatic finish_run();
      $display("Value errors: %0d, other errors: %0d", err_val, err_other);
      if ((err_val + err_other) == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   endtask

   task automatic report_timeout(input string what);
      err_other++;
      $display("Timed out waiting for %s", what);
   endtask

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      assert (got === exp) else begin
         err_val++;
         $display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
      end
   endtask

   // Never more than one port request at a time
   always @(negedge clk_div2) begin
      if (i_rst_n) begin
         assert ($onehot0(o_port_req)) else begin
            err_val++;
            $display("ERROR o_port_req 0x%0h has more than one bit high", o_port_req);
         end
      end
   end

   // ------------------------------------------------------------------
   // Random ack delay from an 8-bit Fibonacci LFSR with taps 8 6 5 4
   // ------------------------------------------------------------------
   function automatic logic [7:0] lfsr_next(input logic [7:0] s);
      return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
   endfunction

   task automatic rand_delay(output int d);
      d = 0;
      repeat (2) begin
         lfsr = lfsr_next(lfsr);
         d    = (d << 1) | int'(lfsr[0]);
      end
   endtask

   // ------------------------------------------------------------------
   // Host request side
   // ------------------------------------------------------------------
   task automatic wait_req_ack(input logic level, input int limit, output logic ok);
      int n;
      n = 0;
      do begin
         @(negedge clk_div2);
         n++;
      end while (o_req_ack !== level && n < limit);
      ok = (o_req_ack === level);
   endtask

   task automatic start_req(input int idx);
      @(posedge clk_div2);
      i_req_pf        <= tbl[idx].pf;
      i_req_vf        <= tbl[idx].vf;
      i_req_vf_active <= tbl[idx].vf_active;
      i_req_data      <= tbl[idx].data;
      i_req           <= 1'b1;
   endtask

   task automatic release_req();
      logic ok;
      @(posedge clk_div2);
      i_req <= 1'b0;
      wait_req_ack(1'b0, TMO, ok);
      if (!ok) report_timeout("o_req_ack to fall");
   endtask

   task automatic send_req(input int idx);
      logic ok;
      start_req(idx);
      wait_req_ack(1'b1, TMO, ok);
      if (!ok) report_timeout("o_req_ack to rise");
      release_req();
   endtask

   task automatic wait_deliv(input int target);
      int n;
      n = 0;
      while (deliv_cnt < target && n < TMO * 4) begin
         @(negedge clk_div2);
         n++;
      end
      if (deliv_cnt < target) report_timeout("all items delivered");
   endtask

   // ------------------------------------------------------------------
   // Port responder that expects items in table order
   // ------------------------------------------------------------------
   task automatic port_responder();
      int                       n;
      int                       d;
      int                       idx;
      afu_route_pkg::port_vec_t seen;
      forever begin
         n = 0;
         do begin
            @(negedge clk_div2);
            n++;
         end while (o_port_req == '0 && n < IDLE_TMO);
         if (o_port_req == '0) report_timeout("o_port_req");
         idx  = deliv_cnt % NUM_ENT;
         seen = o_port_req;
         check_val("o_port_req", 32'(seen), 32'(3'b001 << tbl[idx].port));
         check_val("o_port_pf", 32'(o_port_pf), 32'(tbl[idx].pf));
         check_val("o_port_vf", 32'(o_port_vf), 32'(tbl[idx].vf));
         check_val("o_port_vf_active", 32'(o_port_vf_active),
                   32'(tbl[idx].vf_active));
         check_val("o_port_data", o_port_data, tbl[idx].data);
         // Stalled port for the back-pressure phase
         n = 0;
         while (hold && n < IDLE_TMO) begin
            @(negedge clk_div2);
            n++;
         end
         if (hold) report_timeout("port hold release");
         rand_delay(d);
         repeat (d) @(posedge clk_div2);
         @(posedge clk_div2);
         i_port_ack <= seen;
         n = 0;
         do begin
            @(negedge clk_div2);
            n++;
         end while (o_port_req != '0 && n < TMO);
         if (o_port_req != '0) report_timeout("o_port_req to fall");
         @(posedge clk_div2);
         i_port_ack <= '0;
         deliv_cnt++;
      end
   endtask

   // ------------------------------------------------------------------
   // FLR sequence for one table entry
   // ------------------------------------------------------------------
   task automatic flr_case(input int idx);
      int                       n;
      int                       d;
      afu_route_pkg::port_vec_t seen;
      @(posedge clk_div2);
      i_flr_pf        <= tbl[idx].pf;
      i_flr_vf        <= tbl[idx].vf;
      i_flr_vf_active <= tbl[idx].vf_active;
      i_flr_req       <= 1'b1;
      n = 0;
      do begin
         @(negedge clk_div2);
         n++;
      end while (o_flr_port_req == '0 && n < TMO);
      if (o_flr_port_req == '0) report_timeout("o_flr_port_req");
      seen = o_flr_port_req;
      check_val("o_flr_port_req", 32'(seen), 32'(3'b001 << tbl[idx].port));
      check_val("o_flr_port_pf", 32'(o_flr_port_pf), 32'(tbl[idx].pf));
      check_val("o_flr_port_vf", 32'(o_flr_port_vf), 32'(tbl[idx].vf));
      check_val("o_flr_ack", 32'(o_flr_ack), 32'd0);
      rand_delay(d);
      repeat (d) @(posedge clk_div2);
      @(posedge clk_div2);
      i_flr_port_ack <= seen;
      // Host ack must stay low until the port cycle is over
      n = 0;
      do begin
         @(negedge clk_div2);
         check_val("o_flr_ack", 32'(o_flr_ack), 32'd0);
         n++;
      end while (o_flr_port_req != '0 && n < TMO);
      if (o_flr_port_req != '0) report_timeout("o_flr_port_req to fall");
      @(posedge clk_div2);
      i_flr_port_ack <= '0;
      n = 0;
      do begin
         @(negedge clk_div2);
         n++;
      end while (!o_flr_ack && n < TMO);
      if (!o_flr_ack) report_timeout("o_flr_ack to rise");
      @(posedge clk_div2);
      i_flr_req <= 1'b0;
      n = 0;
      do begin
         @(negedge clk_div2);
         n++;
      end while (o_flr_ack && n < TMO);
      if (o_flr_ack) report_timeout("o_flr_ack to fall");
   endtask

   // ------------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------------
   initial begin
      logic ok;
      logic stalled;
      int   accepted;
      // pf, vf, vf_active, payload, expected port
      tbl[0]  = '{3'd0, 4'd0,  1'b0, 32'h1000_0a00, 2'd0};
      tbl[1]  = '{3'd0, 4'd0,  1'b1, 32'h2000_0b01, 2'd1};
      tbl[2]  = '{3'd0, 4'd1,  1'b1, 32'h3000_0c02, 2'd1};
      tbl[3]  = '{3'd0, 4'd2,  1'b1, 32'h4000_0d03, 2'd1};
      tbl[4]  = '{3'd0, 4'd3,  1'b1, 32'h5000_0e04, 2'd2};
      tbl[5]  = '{3'd0, 4'd15, 1'b1, 32'h6000_0f05, 2'd2};
      tbl[6]  = '{3'd1, 4'd0,  1'b0, 32'h7000_1006, 2'd2};
      tbl[7]  = '{3'd2, 4'd1,  1'b1, 32'h8000_1107, 2'd2};
      tbl[8]  = '{3'd3, 4'd0,  1'b1, 32'h9000_1208, 2'd2};
      tbl[9]  = '{3'd4, 4'd7,  1'b0, 32'ha000_1309, 2'd2};
      tbl[10] = '{3'd5, 4'd2,  1'b1, 32'hb000_140a, 2'd2};
      // VF number ignored when no VF is active
      tbl[11] = '{3'd0, 4'd5,  1'b0, 32'hc000_150b, 2'd0};
      i_rst_n         = 1'b0;
      i_req           = 1'b0;
      i_req_pf        = '0;
      i_req_vf        = '0;
      i_req_vf_active = 1'b0;
      i_req_data      = '0;
      i_port_ack      = '0;
      i_flr_req       = 1'b0;
      i_flr_pf        = '0;
      i_flr_vf        = '0;
      i_flr_vf_active = 1'b0;
      i_flr_port_ack  = '0;
      repeat (4) @(posedge clk_div2);
      i_rst_n <= 1'b1;
      @(negedge clk_div2);
      check_val("o_req_ack", 32'(o_req_ack), 32'd0);
      check_val("o_port_req", 32'(o_port_req), 32'd0);
      check_val("o_flr_port_req", 32'(o_flr_port_req), 32'd0);
      check_val("o_flr_ack", 32'(o_flr_ack), 32'd0);
      fork
         port_responder();
      join_none
      // Routing and ordering with random ack delays
      for (int i = 0; i < NUM_ENT; i++) begin
         send_req(i);
      end
      wait_deliv(NUM_ENT);
      // Back-pressure with a stalled port must stop the host ack
      hold     = 1'b1;
      stalled  = 1'b0;
      accepted = 0;
      for (int i = 0; i < 6 && !stalled; i++) begin
         start_req(i);
         wait_req_ack(1'b1, 30, ok);
         if (ok) begin
            accepted++;
            release_req();
         end else begin
            stalled = 1'b1;
         end
      end
      assert (stalled && accepted <= 3) else begin
         err_other++;
         $display("Host ack not withheld in time, %0d requests accepted", accepted);
      end
      hold = 1'b0;
      wait_req_ack(1'b1, TMO, ok);
      if (!ok) report_timeout("o_req_ack after port release");
      release_req();
      for (int i = accepted + 1; i < 6; i++) begin
         send_req(i);
      end
      wait_deliv(NUM_ENT + 6);
      // FLR routing
      for (int i = 0; i < NUM_ENT; i++) begin
         flr_case(i);
      end
      finish_run();
   end

endmodule

//--- sources.f
afu_route_pkg.sv
host_rx_stage.sv
pfvf_route_stage.sv
port_out_stage.sv
flr_router.sv
afu_route_top.sv
tb_afu_route.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the AFU routing testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_afu_route \
   -f sources.f

sim_out="$(./obj_dir/Vtb_afu_route)"
echo "${sim_out}"

if grep -q "Regression passed" <<< "${sim_out}"; then
   exit 0
else
   exit 1
fi
